// ==== src.f ====
+incdir+include
hdl/core_pkg.sv
hdl/core_ifu.sv
hdl/core_idu.sv
hdl/core_regfile.sv
hdl/core_csr.sv
hdl/core_exu.sv
hdl/core_lsu.sv
hdl/core_pcu.sv
hdl/core_top.sv
verif/core_tb.sv

// ==== verif/core_tb.sv ====
`include "core_config.svh"

module core_tb import core_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS = 200;
    localparam int RAND_END   = 184;
    localparam int CYCLE_LIMIT = PROG_WORDS * 16 + 100;
    localparam word_t LOOP_PC = 32'(4 * (PROG_WORDS - 1));

    logic     clock;
    logic     arst_n;
    mem_req_t mem_req;
    logic     mem_ready;
    word_t    mem_rdata;
    word_t    pc;
    word_t    inst;
    logic     retire;

    word_t    mem [1024];
    word_t    ref_mem [1024];
    word_t    ref_regs [16];
    word_t    ref_pc, ref_mstatus, ref_mtvec, ref_mepc, ref_mcause;
    mem_req_t held;
    logic     busy, seen_first, done;
    int       waits, pick, errors, cycles;

    core_top DUT (
        .clock(clock), .arst_n(arst_n), .mem_req(mem_req), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata), .pc(pc), .inst(inst), .retire(retire)
    );

    always #50 clock = !clock;

    task automatic check_val(input string name, input logic [69:0] got, input logic [69:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
                                    input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                    input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t enc_s(input int imm, input int rs2, input int f3);
        return {imm[11:5], rs2[4:0], 5'd0, f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic put(input int i, input word_t w);
        mem[i]     = w;
        ref_mem[i] = w;
    endtask

    // words 5 to 9 hold the trap handler, which steps mepc past the ecall.
    task automatic build_program();
        int brf [6] = '{0, 1, 4, 5, 6, 7};
        int ldf [5] = '{0, 1, 2, 4, 5};
        int csrs [3] = '{`CSR_MSTATUS, `CSR_MEPC, `CSR_MCAUSE};
        int kind, f3, k, off, imm;
        for (int i = 0; i < 1024; i++) begin
            put(i, i * 32'h9e37_79b1 + 32'h1234_5678);
        end
        put(0, enc_i(20, 0, 0, 1, 7'h13));
        put(1, enc_i(`CSR_MTVEC, 1, 1, 0, 7'h73));
        put(2, enc_j(32, 0));
        put(3, enc_i(0, 0, 0, 0, 7'h13));
        put(4, enc_i(0, 0, 0, 0, 7'h13));
        put(5, enc_i(`CSR_MCAUSE, 0, 2, 14, 7'h73));
        put(6, enc_i(`CSR_MEPC, 0, 2, 15, 7'h73));
        put(7, enc_i(4, 15, 0, 15, 7'h13));
        put(8, enc_i(`CSR_MEPC, 15, 1, 0, 7'h73));
        put(9, 32'h3020_0073);
        put(10, 32'h0000_0073);
        for (int i = 11; i < RAND_END; i++) begin
            kind = $urandom % 16;
            f3   = $urandom % 8;
            k    = 1 + $urandom % ((RAND_END - i) < 6 ? (RAND_END - i) : 6);
            off  = 32'h400 + $urandom % 32'h400;
            case (kind)
                4, 5, 6: put(i, enc_r(((f3 == 0 || f3 == 5) && $urandom % 2) ? 32 : 0,
                                      $urandom % 16, $urandom % 16, f3, $urandom % 16));
                7: put(i, {$urandom} & 32'hffff_f000 | ($urandom % 16) << 7
                          | (($urandom % 2) ? 32'h37 : 32'h17));
                8: put(i, enc_b(4 * k, $urandom % 16, $urandom % 16, brf[$urandom % 6]));
                9: put(i, enc_j(4 * k, $urandom % 16));
                10: put(i, enc_i(4 * (i + k), 0, 0, $urandom % 16, 7'h67));
                11: begin
                    f3 = ldf[$urandom % 5];
                    off = off & ~((1 << f3[1:0]) - 1);
                    put(i, enc_i(off, 0, f3, $urandom % 16, 7'h03));
                end
                12: begin
                    f3 = $urandom % 3;
                    put(i, enc_s(off & ~((1 << f3) - 1), $urandom % 16, f3));
                end
                13: put(i, enc_i(csrs[$urandom % 3], $urandom % 16, 1 + $urandom % 2,
                                 $urandom % 16, 7'h73));
                14: put(i, 32'h0000_0073);
                default: begin
                    imm = $urandom % 4096;
                    if (f3 == 1 || f3 == 5) begin
                        imm = (imm % 32) | ((f3 == 5 && $urandom % 2) ? 32'h400 : 0);
                    end
                    put(i, enc_i(imm, $urandom % 16, f3, $urandom % 16, 7'h13));
                end
            endcase
        end
        for (int r = 1; r < 16; r++) begin
            put(RAND_END + r - 1, enc_s(32'h700 + 4 * r, r, 2));
        end
        put(PROG_WORDS - 1, enc_j(0, 0));
    endtask

    function automatic word_t alu(input int f3, input word_t x, input word_t y, input logic alt);
        case (f3)
            0: return alt ? x - y : x + y;
            1: return x << y[4:0];
            2: return {31'b0, $signed(x) < $signed(y)};
            3: return {31'b0, x < y};
            4: return x ^ y;
            5: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input int f3, input word_t x, input word_t y);
        case (f3)
            0: return x == y;
            1: return x != y;
            4: return $signed(x) < $signed(y);
            5: return $signed(x) >= $signed(y);
            6: return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic word_t csr_read(input int addr);
        case (addr)
            `CSR_MSTATUS: return ref_mstatus;
            `CSR_MTVEC: return ref_mtvec;
            `CSR_MEPC: return ref_mepc;
            `CSR_MCAUSE: return ref_mcause;
            default: return '0;
        endcase
    endfunction

    task automatic csr_write(input int addr, input word_t v);
        case (addr)
            `CSR_MSTATUS: ref_mstatus = v;
            `CSR_MTVEC: ref_mtvec = v;
            `CSR_MEPC: ref_mepc = v;
            `CSR_MCAUSE: ref_mcause = v;
            default: ;
        endcase
    endtask

    task automatic write_reg(input int rd, input word_t v);
        if (rd != 0) begin
            ref_regs[rd] = v;
        end
    endtask

    // runs one instruction of the reference model in its retire cycle.
    task automatic step_model();
        word_t    ins, a, b, immi, imms, immb, immu, immj, nxt, addr, w, old;
        int       rd, f3, sh;
        mem_req_t exp_req;
        ins  = ref_mem[ref_pc[11:2]];
        rd   = ins[11:7];
        f3   = ins[14:12];
        a    = ref_regs[ins[18:15]];
        b    = ref_regs[ins[23:20]];
        immi = {{20{ins[31]}}, ins[31:20]};
        imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immu = {ins[31:12], 12'b0};
        immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt  = ref_pc + 4;
        case (ins[6:0])
            7'h37: write_reg(rd, immu);
            7'h17: write_reg(rd, ref_pc + immu);
            7'h6f: begin
                write_reg(rd, ref_pc + 4);
                nxt = ref_pc + immj;
            end
            7'h67: begin
                nxt = (a + immi) & ~32'd1;
                write_reg(rd, ref_pc + 4);
            end
            7'h63: if (branch_taken(f3, a, b)) nxt = ref_pc + immb;
            7'h03: begin
                addr = a + immi;
                check_val("mem_req.addr", mem_req.addr, {addr[31:2], 2'b00});
                check_val("mem_req.we", mem_req.we, 1'b0);
                w = ref_mem[addr[11:2]] >> (8 * addr[1:0]);
                case (f3)
                    0: write_reg(rd, {{24{w[7]}}, w[7:0]});
                    1: write_reg(rd, {{16{w[15]}}, w[15:0]});
                    4: write_reg(rd, {24'b0, w[7:0]});
                    5: write_reg(rd, {16'b0, w[15:0]});
                    default: write_reg(rd, w);
                endcase
            end
            7'h23: begin
                addr = a + imms;
                sh = addr[1:0];
                exp_req = '0;
                exp_req.valid = 1'b1;
                exp_req.we = 1'b1;
                exp_req.addr = {addr[31:2], 2'b00};
                exp_req.wdata = b << (8 * sh);
                exp_req.strb = (f3 == 0) ? 4'b0001 << sh : (f3 == 1) ? 4'b0011 << sh : 4'hf;
                check_val("mem_req", mem_req, exp_req);
                for (int i = 0; i < 4; i++) begin
                    if (exp_req.strb[i]) begin
                        ref_mem[addr[11:2]][8 * i +: 8] = exp_req.wdata[8 * i +: 8];
                    end
                end
            end
            7'h13: write_reg(rd, alu(f3, a, immi, f3 == 5 && ins[30]));
            7'h33: write_reg(rd, alu(f3, a, b, ins[30]));
            default: begin
                old = csr_read(ins[31:20]);
                if (f3 == 1 || f3 == 2) begin
                    csr_write(ins[31:20], (f3 == 2) ? (old | a) : a);
                    write_reg(rd, old);
                end else if (ins[21]) begin
                    nxt = ref_mepc;
                    ref_mstatus[3] = ref_mstatus[7];
                    ref_mstatus[7] = 1'b1;
                end else begin
                    ref_mepc = ref_pc;
                    ref_mcause = `ECALL_CAUSE;
                    ref_mstatus[7] = ref_mstatus[3];
                    ref_mstatus[3] = 1'b0;
                    ref_mstatus[12:11] = 2'b11;
                    nxt = {ref_mtvec[31:2], 2'b00};
                end
            end
        endcase
        ref_pc = nxt;
    endtask

    always @(negedge clock) begin
        if (!arst_n) begin
            check_val("mem_req.valid", mem_req.valid, 1'b0);
            check_val("retire", retire, 1'b0);
        end
    end

    always @(posedge clock) begin
        if (arst_n) begin
            if (mem_req.valid && !seen_first) begin
                seen_first = 1'b1;
                check_val("mem_req.addr", mem_req.addr, `RESET_PC);
                check_val("mem_req.we", mem_req.we, 1'b0);
            end
            if (retire && !done) begin
                check_val("pc", pc, ref_pc);
                check_val("inst", inst, ref_mem[ref_pc[11:2]]);
                if (ref_pc == LOOP_PC) done <= 1'b1;
                else step_model();
            end
            // memory with 0 to 3 wait states per request.
            if (busy) begin
                check_val("mem_req", mem_req, held);
            end
            if (mem_ready) begin
                mem_ready <= 1'b0;
                busy <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                    if (mem_req.we && mem_req.strb[i]) begin
                        mem[mem_req.addr[11:2]][8 * i +: 8] <= mem_req.wdata[8 * i +: 8];
                    end
                end
            end else if (mem_req.valid) begin
                if (!busy) begin
                    busy <= 1'b1;
                    held <= mem_req;
                    pick = $urandom % 4;
                    if (pick == 0) begin
                        mem_ready <= 1'b1;
                        mem_rdata <= mem[mem_req.addr[11:2]];
                    end else begin
                        waits <= pick - 1;
                    end
                end else if (waits == 0) begin
                    mem_ready <= 1'b1;
                    mem_rdata <= mem[mem_req.addr[11:2]];
                end else begin
                    waits <= waits - 1;
                end
            end
        end
    end

    initial begin
        clock = 1'b0;
        arst_n = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy = 1'b0;
        seen_first = 1'b0;
        done = 1'b0;
        errors = 0;
        cycles = 0;
        ref_pc = `RESET_PC;
        ref_mstatus = '0;
        ref_mtvec = '0;
        ref_mepc = '0;
        ref_mcause = '0;
        for (int r = 0; r < 16; r++) begin
            ref_regs[r] = '0;
        end
        void'($urandom(13));
        build_program();
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        while (!done && cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        @(negedge clock);
        if (!done) begin
            errors++;
            $display("timeout: the core did not reach the final loop in %0d cycles", cycles);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hdl/core_top.sv ====
module core_top import core_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    output mem_req_t mem_req,
    input  logic     mem_ready,
    input  word_t    mem_rdata,
    output word_t    pc,
    output word_t    inst,
    output logic     retire
);

    decode_t  dec;
    mem_req_t fetch_req, data_req;
    logic     fetching, fetch_ready, data_ready, is_mem, mem_done, taken;
    word_t    rs1_val, rs2_val, result, load_val, csr_rdata;
    word_t    trap_vec, epc, target, link, wb_data;

    // the fetch unit owns the memory port during the fetch phase.
    assign mem_req     = fetching ? fetch_req : data_req;
    assign fetch_ready = fetching && mem_ready;
    assign data_ready  = !fetching && mem_ready;

    assign is_mem = (dec.mem_op != MEM_NONE);
    assign link   = pc + 32'd4;
    assign target = (dec.br_op == BR_JALR) ? result : pc + dec.imm;

    always_comb begin
        case (dec.wb_sel)
            WB_MEM:  wb_data = load_val;
            WB_CSR:  wb_data = csr_rdata;
            WB_LINK: wb_data = link;
            default: wb_data = result;
        endcase
    end

    core_ifu u_ifu (
        .clock(clock), .arst_n(arst_n), .pc(pc), .fetch_ready(fetch_ready),
        .fetch_rdata(mem_rdata), .is_mem(is_mem), .mem_done(mem_done),
        .fetch_req(fetch_req), .fetching(fetching), .inst(inst), .retire(retire)
    );

    core_idu u_idu (.inst(inst), .dec(dec));

    core_regfile u_regfile (
        .clock(clock), .arst_n(arst_n), .we(retire && (dec.wb_sel != WB_NONE)),
        .waddr(dec.rd), .raddr1(dec.rs1), .raddr2(dec.rs2), .wdata(wb_data),
        .rdata1(rs1_val), .rdata2(rs2_val)
    );

    core_csr u_csr (
        .clock(clock), .arst_n(arst_n), .retire(retire), .dec(dec), .pc(pc),
        .wdata(rs1_val), .rdata(csr_rdata), .trap_vec(trap_vec), .epc(epc)
    );

    core_exu u_exu (
        .dec(dec), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .result(result), .taken(taken)
    );

    core_lsu u_lsu (
        .clock(clock), .arst_n(arst_n), .active(is_mem && !fetching), .dec(dec),
        .addr(result), .store_val(rs2_val), .data_req(data_req), .data_ready(data_ready),
        .data_rdata(mem_rdata), .load_val(load_val), .done(mem_done)
    );

    core_pcu u_pcu (
        .clock(clock), .arst_n(arst_n), .retire(retire), .dec(dec), .taken(taken),
        .target(target), .trap_vec(trap_vec), .epc(epc), .pc(pc)
    );

endmodule

// ==== hdl/core_pcu.sv ====
`include "core_config.svh"

module core_pcu import core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  logic    retire,
    input  decode_t dec,
    input  logic    taken,
    input  word_t   target,
    input  word_t   trap_vec,
    input  word_t   epc,
    output word_t   pc
);

    word_t pc_next;

    always_comb begin
        if (dec.sys_op == SYS_ECALL) begin
            pc_next = trap_vec;
        end else if (dec.sys_op == SYS_MRET) begin
            pc_next = epc;
        end else if (taken) begin
            pc_next = (dec.br_op == BR_JALR) ? {target[31:1], 1'b0} : target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (retire) begin
            pc <= pc_next;
        end
    end

    // targets come from the decoder, the ALU and the CSRs.
    assert property (@(posedge clock) disable iff (!arst_n)
        retire |=> pc[1:0] == 2'b00)
        else $error("misaligned pc %h", pc);

endmodule

// ==== hdl/core_lsu.sv ====
module core_lsu import core_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     active,
    input  decode_t  dec,
    input  word_t    addr,
    input  word_t    store_val,
    output mem_req_t data_req,
    input  logic     data_ready,
    input  word_t    data_rdata,
    output word_t    load_val,
    output logic     done
);

    logic       armed;
    logic [4:0] shift;
    strb_t      strb;
    word_t      raw;

    // active rises in execute; the request waits one cycle for the memory state.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            armed <= 1'b0;
        end else begin
            armed <= active && !done;
        end
    end

    assign shift = {addr[1:0], 3'b000};

    always_comb begin
        case (dec.mem_size)
            SIZE_BYTE: strb = 4'b0001 << addr[1:0];
            SIZE_HALF: strb = 4'b0011 << addr[1:0];
            default:   strb = 4'b1111;
        endcase
    end

    always_comb begin
        data_req       = '0;
        data_req.valid = active && armed;
        data_req.we    = (dec.mem_op == MEM_STORE);
        data_req.addr  = {addr[31:2], 2'b00};
        data_req.wdata = store_val << shift;
        data_req.strb  = strb;
    end

    assign done = data_req.valid && data_ready;

    assign raw = data_rdata >> shift;

    always_comb begin
        case (dec.mem_size)
            SIZE_BYTE: load_val = dec.mem_unsigned ? {24'b0, raw[7:0]}
                                                   : {{24{raw[7]}}, raw[7:0]};
            SIZE_HALF: load_val = dec.mem_unsigned ? {16'b0, raw[15:0]}
                                                   : {{16{raw[15]}}, raw[15:0]};
            default:   load_val = raw;
        endcase
    end

    // a store that crosses a word boundary loses strobe bits in the shift.
    assert property (@(posedge clock) disable iff (!arst_n)
        data_req.valid && data_req.we |-> $countones(data_req.strb) == (32'd1 << dec.mem_size))
        else $error("store request with a truncated byte strobe");

endmodule

// ==== hdl/core_exu.sv ====
module core_exu import core_pkg::*; (
    input  decode_t dec,
    input  word_t   pc,
    input  word_t   rs1_val,
    input  word_t   rs2_val,
    output word_t   result,
    output logic    taken
);

    word_t op_a, op_b;
    logic  lt_s, lt_u, eq;

    assign op_a = dec.a_pc ? pc : rs1_val;
    assign op_b = dec.b_imm ? dec.imm : rs2_val;

    // loads and stores take their address from the add below.
    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << op_b[4:0];
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> op_b[4:0];
            ALU_SRA:  result = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   result = op_a | op_b;
            default:  result = op_a & op_b;
        endcase
    end

    assign eq   = (rs1_val == rs2_val);
    assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
    assign lt_u = (rs1_val < rs2_val);

    always_comb begin
        case (dec.br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== hdl/core_csr.sv ====
`include "core_config.svh"

module core_csr import core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  logic    retire,
    input  decode_t dec,
    input  word_t   pc,
    input  word_t   wdata,
    output word_t   rdata,
    output word_t   trap_vec,
    output word_t   epc
);

    word_t mstatus, mtvec, mepc, mcause;
    word_t new_val;

    always_comb begin
        case (dec.csr_addr)
            `CSR_MSTATUS: rdata = mstatus;
            `CSR_MTVEC:   rdata = mtvec;
            `CSR_MEPC:    rdata = mepc;
            `CSR_MCAUSE:  rdata = mcause;
            default:      rdata = '0;
        endcase
    end

    assign new_val = (dec.sys_op == SYS_CSRRS) ? (rdata | wdata) : wdata;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (retire) begin
            if ((dec.sys_op == SYS_CSRRW) || (dec.sys_op == SYS_CSRRS)) begin
                case (dec.csr_addr)
                    `CSR_MSTATUS: mstatus <= new_val;
                    `CSR_MTVEC:   mtvec   <= new_val;
                    `CSR_MEPC:    mepc    <= new_val;
                    `CSR_MCAUSE:  mcause  <= new_val;
                    default: ;
                endcase
            end else if (dec.sys_op == SYS_ECALL) begin
                mepc    <= pc;
                mcause  <= `ECALL_CAUSE;
                // stack MIE into MPIE and record machine mode in MPP.
                mstatus <= {mstatus[31:13], 2'b11, mstatus[10:8], mstatus[3],
                            mstatus[6:4], 1'b0, mstatus[2:0]};
            end else if (dec.sys_op == SYS_MRET) begin
                mstatus <= {mstatus[31:8], 1'b1, mstatus[6:4], mstatus[7], mstatus[2:0]};
            end
        end
    end

    assign trap_vec = {mtvec[31:2], 2'b00};
    assign epc      = mepc;

endmodule

// ==== hdl/core_regfile.sv ====
`include "core_config.svh"

module core_regfile import core_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      we,
    input  reg_addr_t waddr,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so it keeps its reset value.
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== hdl/core_idu.sv ====
module core_idu import core_pkg::*; (
    input  word_t   inst,
    output decode_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec          = '0;
        dec.rs1      = inst[18:15];
        dec.rs2      = inst[23:20];
        dec.rd       = inst[10:7];
        dec.csr_addr = inst[31:20];
        dec.mem_size = mem_size_t'(funct3[1:0]);
        dec.mem_unsigned = funct3[2];
        case (opcode)
            7'b0110111: begin
                // lui adds the immediate to a forced x0.
                dec.rs1    = '0;
                dec.imm    = {inst[31:12], 12'b0};
                dec.b_imm  = 1'b1;
                dec.wb_sel = WB_ALU;
            end
            7'b0010111: begin
                dec.imm    = {inst[31:12], 12'b0};
                dec.a_pc   = 1'b1;
                dec.b_imm  = 1'b1;
                dec.wb_sel = WB_ALU;
            end
            7'b1101111: begin
                dec.imm    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                dec.br_op  = BR_JAL;
                dec.wb_sel = WB_LINK;
            end
            7'b1100111: begin
                dec.imm    = {{20{inst[31]}}, inst[31:20]};
                dec.b_imm  = 1'b1;
                dec.br_op  = BR_JALR;
                dec.wb_sel = WB_LINK;
            end
            7'b1100011: begin
                dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                case (funct3)
                    3'b000:  dec.br_op = BR_BEQ;
                    3'b001:  dec.br_op = BR_BNE;
                    3'b100:  dec.br_op = BR_BLT;
                    3'b101:  dec.br_op = BR_BGE;
                    3'b110:  dec.br_op = BR_BLTU;
                    default: dec.br_op = BR_BGEU;
                endcase
            end
            7'b0000011: begin
                dec.imm    = {{20{inst[31]}}, inst[31:20]};
                dec.b_imm  = 1'b1;
                dec.mem_op = MEM_LOAD;
                dec.wb_sel = WB_MEM;
            end
            7'b0100011: begin
                dec.imm    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.b_imm  = 1'b1;
                dec.mem_op = MEM_STORE;
            end
            7'b0010011: begin
                dec.imm    = {{20{inst[31]}}, inst[31:20]};
                dec.b_imm  = 1'b1;
                dec.alu_op = alu_from_funct(funct3, (funct3 == 3'b101) && inst[30]);
                dec.wb_sel = WB_ALU;
            end
            7'b0110011: begin
                dec.alu_op = alu_from_funct(funct3, inst[30]);
                dec.wb_sel = WB_ALU;
            end
            7'b1110011: begin
                if (funct3 == 3'b001) begin
                    dec.sys_op = SYS_CSRRW;
                    dec.wb_sel = WB_CSR;
                end else if (funct3 == 3'b010) begin
                    dec.sys_op = SYS_CSRRS;
                    dec.wb_sel = WB_CSR;
                end else begin
                    // mret sets bit 21 of the funct12 field, ecall leaves it clear.
                    dec.sys_op = inst[21] ? SYS_MRET : SYS_ECALL;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/core_ifu.sv ====
module core_ifu import core_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    input  word_t    pc,
    input  logic     fetch_ready,
    input  word_t    fetch_rdata,
    input  logic     is_mem,
    input  logic     mem_done,
    output mem_req_t fetch_req,
    output logic     fetching,
    output word_t    inst,
    output logic     retire
);

    fetch_state_t state, state_next;
    logic         running;

    // running holds the first request back until one edge after reset release.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_FETCH;
            running <= 1'b0;
        end else begin
            state   <= state_next;
            running <= 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH:   if (fetch_req.valid && fetch_ready) state_next = ST_EXECUTE;
            ST_EXECUTE: state_next = is_mem ? ST_MEMORY : ST_FETCH;
            ST_MEMORY:  if (mem_done) state_next = ST_FETCH;
            default:    state_next = ST_FETCH;
        endcase
    end

    always_ff @(posedge clock) begin
        if (fetch_req.valid && fetch_ready) begin
            inst <= fetch_rdata;
        end
    end

    always_comb begin
        fetch_req       = '0;
        fetch_req.valid = running && (state == ST_FETCH);
        fetch_req.addr  = pc;
        fetch_req.strb  = 4'hf;
    end

    assign fetching = (state == ST_FETCH);
    assign retire   = ((state == ST_EXECUTE) && !is_mem) || ((state == ST_MEMORY) && mem_done);

    // the pc feeding the request must not move until memory accepts it.
    assert property (@(posedge clock) disable iff (!arst_n)
        fetch_req.valid && !fetch_ready |=> $stable(fetch_req))
        else $error("fetch request changed during a wait state");

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_t;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

    // encoded as funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_t;

    typedef enum logic [2:0] {WB_NONE, WB_ALU, WB_MEM, WB_CSR, WB_LINK} wb_sel_t;

    typedef enum logic [2:0] {SYS_NONE, SYS_CSRRW, SYS_CSRRS, SYS_ECALL, SYS_MRET} sys_op_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      a_pc;
        logic      b_imm;
        br_op_t    br_op;
        mem_op_t   mem_op;
        mem_size_t mem_size;
        logic      mem_unsigned;
        wb_sel_t   wb_sel;
        sys_op_t   sys_op;
        csr_addr_t csr_addr;
    } decode_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
        strb_t strb;
    } mem_req_t;

    typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_MEMORY} fetch_state_t;

endpackage

// ==== include/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// architectural register count for RV32E.
`define REG_COUNT 16

`define RESET_PC 32'h0000_0000

`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// environment call from machine mode.
`define ECALL_CAUSE 32'd11

`endif
